/* rca_profiler.f */
+incdir+verilog
+incdir+bench
verilog/rca_profiler_pkg.sv
verilog/branch_event_filter.sv
verilog/profile_match.sv
verilog/profile_table.sv
verilog/rca_profiler_top.sv
bench/rca_profiler_tb.sv

/* Bender.yml */
package:
  name: rca_profiler

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rca_profiler_pkg.sv
      - verilog/branch_event_filter.sv
      - verilog/profile_match.sv
      - verilog/profile_table.sv
      - verilog/rca_profiler_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - bench
    files:
      - bench/rca_profiler_tb.sv

/* bench/profiler_model.svh */
`ifndef PROFILER_MODEL_SVH
`define PROFILER_MODEL_SVH

// Expected table contents, updated once per accepted branch in issue order
logic [`XLEN-1:0]    exp_addr  [`PROF_ENTRIES];
logic                exp_valid [`PROF_ENTRIES];
logic [`COUNT_W-1:0] exp_count [`PROF_ENTRIES];

task automatic clear_reference();
    for (int i = 0; i < `PROF_ENTRIES; i++) begin
        exp_addr[i]  = '0;
        exp_valid[i] = 1'b0;
        exp_count[i] = '0;
    end
endtask

task automatic apply_branch(input logic [`XLEN-1:0] pc, input logic short_back);
    int slot;
    int victim;
    bit found_free;
    slot       = -1;
    victim     = 0;
    found_free = 1'b0;
    for (int i = 0; i < `PROF_ENTRIES; i++) begin
        if (exp_valid[i] && exp_addr[i] == pc) begin
            slot = i;
        end
    end
    if (slot >= 0) begin
        // Saturated hit ages every valid entry before counting
        if (exp_count[slot] == {`COUNT_W{1'b1}}) begin
            for (int i = 0; i < `PROF_ENTRIES; i++) begin
                if (exp_valid[i]) begin
                    exp_count[i] = exp_count[i] / 2;
                end
            end
        end
        exp_count[slot] = exp_count[slot] + 1'b1;
    end else if (short_back) begin
        for (int i = 0; i < `PROF_ENTRIES; i++) begin
            if (!found_free && !exp_valid[i]) begin
                victim     = i;
                found_free = 1'b1;
            end
        end
        // Table full, so evict the first entry holding the smallest count
        if (!found_free) begin
            for (int i = 1; i < `PROF_ENTRIES; i++) begin
                if (exp_count[i] < exp_count[victim]) begin
                    victim = i;
                end
            end
        end
        exp_addr[victim]  = pc;
        exp_valid[victim] = 1'b1;
        exp_count[victim] = 1;
    end
endtask

`endif

/* bench/rca_profiler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rca_profiler_config.svh"

module rca_profiler_tb;

    localparam int CLK_PERIOD       = 20;
    localparam int RANDOM_PHASES    = 12;
    localparam int CYCLES_PER_PHASE = 60;
    localparam int READOUT_CYCLES   = 3 + `PROF_ENTRIES;
    localparam int DIRECTED_CYCLES  = 24;
    localparam int TOTAL_CYCLES     = 4 + 2 * READOUT_CYCLES + DIRECTED_CYCLES +
                                      RANDOM_PHASES * (CYCLES_PER_PHASE + READOUT_CYCLES);

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic                              branch_issue;
    logic [`XLEN-1:0]                  branch_pc;
    logic [`OFFSET_W-1:0]              branch_offset;
    logic                              branch_taken;
    logic                              profiler_lock;
    logic [`PROF_IDX_W-1:0]            rd_index;
    rca_profiler_pkg::profiler_entry_t rd_entry;

    int unsigned      rng_state = 45415;
    logic [`XLEN-1:0] last_pc   = 32'h0000_1000;
    int               errors    = 0;
    int               checks    = 0;

    `include "profiler_model.svh"

    rca_profiler_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_issue  (branch_issue),
        .branch_pc     (branch_pc),
        .branch_offset (branch_offset),
        .branch_taken  (branch_taken),
        .profiler_lock (profiler_lock),
        .rd_index      (rd_index),
        .rd_entry      (rd_entry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    // Twelve candidate loop heads, word aligned
    function automatic logic [`XLEN-1:0] pool_pc(input int unsigned idx);
        return 32'h0000_1000 + 32'(idx) * 32'h40;
    endfunction

    task automatic drive_cycle(input logic issue, input logic taken,
                               input logic [`XLEN-1:0] pc, input int off, input logic lock);
        @(posedge clk);
        #2;
        branch_issue  = issue;
        branch_taken  = taken;
        branch_pc     = pc;
        branch_offset = off[`OFFSET_W-1:0];
        profiler_lock = lock;
        if (issue && taken && !lock) begin
            apply_branch(pc, (off < 0) && (off >= `SBB_MAX_OFFSET));
        end
    endtask

    task automatic drive_random(input logic lock);
        int unsigned      sel;
        logic [`XLEN-1:0] pc;
        int               off;
        sel = next_rand() % 16;
        // Mix of immediate repeats, a hot set and the full pool
        if (sel < 4) begin
            pc = last_pc;
        end else if (sel < 10) begin
            pc = pool_pc(next_rand() % 3);
        end else begin
            pc = pool_pc(next_rand() % 12);
        end
        sel = next_rand() % 8;
        if (sel < 5) begin
            off = -2 * (1 + int'(next_rand() % 128));
        end else if (sel == 5) begin
            off = -258 - 2 * int'(next_rand() % 4096);
        end else begin
            off = 2 * int'(next_rand() % 2048);
        end
        last_pc = pc;
        drive_cycle(next_rand() % 8 != 0, next_rand() % 4 != 0, pc, off, lock);
    endtask

    // Freeze profiling, let the pipeline drain, then sweep the readout port
    task automatic locked_readout();
        repeat (3) drive_random(1'b1);
        for (int i = 0; i < `PROF_ENTRIES; i++) begin
            drive_random(1'b1);
            rd_index = `PROF_IDX_W'(i);
            #8;
            checks++;
            assert (rd_entry.entry_valid === exp_valid[i] &&
                    rd_entry.taken_count === exp_count[i] &&
                    (!exp_valid[i] || rd_entry.branch_addr === exp_addr[i]))
            else begin
                errors++;
                $display("MISMATCH %0t: index %0d expected valid=%0b count=%0d addr=%h",
                         $time, i, exp_valid[i], exp_count[i], exp_addr[i]);
                $display("MISMATCH %0t: index %0d actual   valid=%0b count=%0d addr=%h",
                         $time, i, rd_entry.entry_valid, rd_entry.taken_count,
                         rd_entry.branch_addr);
            end
        end
    endtask

    initial begin
        #((TOTAL_CYCLES + 200) * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        branch_issue  = 1'b0;
        branch_taken  = 1'b0;
        branch_pc     = '0;
        branch_offset = '0;
        profiler_lock = 1'b0;
        rd_index      = '0;
        clear_reference();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        locked_readout();

        // New PC inserted and repeated back to back until it saturates and ages
        repeat (18) drive_cycle(1'b1, 1'b1, 32'h0000_8000, -64, 1'b0);
        // No insert for forward, long backward or not taken
        drive_cycle(1'b1, 1'b1, 32'h0000_9000, 64, 1'b0);
        drive_cycle(1'b1, 1'b1, 32'h0000_9040, -1024, 1'b0);
        drive_cycle(1'b1, 1'b0, 32'h0000_9080, -8, 1'b0);
        drive_cycle(1'b0, 1'b1, 32'h0000_90c0, -8, 1'b0);
        locked_readout();

        repeat (RANDOM_PHASES) begin
            repeat (CYCLES_PER_PHASE) drive_random(1'b0);
            locked_readout();
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/rca_profiler_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rca_profiler_config.svh"

module rca_profiler_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      branch_issue,
    input  wire logic [`XLEN-1:0]          branch_pc,
    input  wire logic [`OFFSET_W-1:0]      branch_offset,
    input  wire logic                      branch_taken,
    input  wire logic                      profiler_lock,
    input  wire logic [`PROF_IDX_W-1:0]    rd_index,
    output rca_profiler_pkg::profiler_entry_t rd_entry
);

    rca_profiler_pkg::branch_event_t                      s1_event;
    rca_profiler_pkg::match_result_t                      s2_match;
    rca_profiler_pkg::profiler_entry_t [`PROF_ENTRIES-1:0] table_state;
    logic [`XLEN-1:0]                                     s3_pc;
    logic                                                 s3_valid;

    branch_event_filter u_filter (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_issue  (branch_issue),
        .branch_taken  (branch_taken),
        .profiler_lock (profiler_lock),
        .branch_pc     (branch_pc),
        .branch_offset (branch_offset),
        .event_out     (s1_event)
    );

    profile_match u_match (
        .clk         (clk),
        .rst_n       (rst_n),
        .event_in    (s1_event),
        .table_state (table_state),
        .s3_pc       (s3_pc),
        .s3_valid    (s3_valid),
        .match_out   (s2_match)
    );

    profile_table u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .match_in    (s2_match),
        .rd_index    (rd_index),
        .table_state (table_state),
        .s3_pc       (s3_pc),
        .s3_valid    (s3_valid),
        .rd_entry    (rd_entry)
    );

endmodule

`default_nettype wire

/* verilog/profile_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rca_profiler_config.svh"

module profile_table (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire rca_profiler_pkg::match_result_t        match_in,
    input  wire logic [`PROF_IDX_W-1:0]                 rd_index,
    output rca_profiler_pkg::profiler_entry_t [`PROF_ENTRIES-1:0] table_state,
    output logic [`XLEN-1:0]                            s3_pc,
    output logic                                        s3_valid,
    output rca_profiler_pkg::profiler_entry_t           rd_entry
);

    logic [`XLEN-1:0]       entry_addr  [`PROF_ENTRIES];
    logic [`COUNT_W-1:0]    entry_count [`PROF_ENTRIES];
    logic [`PROF_ENTRIES-1:0] entry_valid;

    // Slot written by the previous item and whether that write was an insert
    logic [`PROF_IDX_W-1:0] last_slot;
    logic                   last_insert;

    logic                   stale_hit;
    logic                   is_hit;
    logic                   do_insert;
    logic [`PROF_IDX_W-1:0] target;
    logic [`PROF_IDX_W-1:0] write_slot;
    logic                   saturated;
    logic                   any_invalid;
    logic [`PROF_IDX_W-1:0] free_idx;
    logic [`PROF_IDX_W-1:0] min_idx;
    logic [`COUNT_W-1:0]    min_count;
    logic [`PROF_IDX_W-1:0] victim;

    // Stage 2 hit on a slot that the previous insert just evicted
    assign stale_hit = match_in.hit && !match_in.same_as_prev && last_insert &&
                       (match_in.hit_idx == last_slot);

    assign is_hit    = match_in.valid && (match_in.same_as_prev ||
                                          (match_in.hit && !stale_hit));
    assign target    = match_in.same_as_prev ? last_slot : match_in.hit_idx;
    assign do_insert = match_in.valid && !is_hit && match_in.sbb;
    assign saturated = &entry_count[target];

    // Lowest free slot, scanned downward so the last assignment wins
    always_comb begin
        any_invalid = 1'b0;
        free_idx    = '0;
        for (int i = `PROF_ENTRIES - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                any_invalid = 1'b1;
                free_idx    = `PROF_IDX_W'(i);
            end
        end
    end

    // Lowest count, strict compare keeps the lowest index on ties
    always_comb begin
        min_count = entry_count[0];
        min_idx   = '0;
        for (int i = 1; i < `PROF_ENTRIES; i++) begin
            if (entry_count[i] < min_count) begin
                min_count = entry_count[i];
                min_idx   = `PROF_IDX_W'(i);
            end
        end
    end

    assign victim     = any_invalid ? free_idx : min_idx;
    assign write_slot = is_hit ? target : victim;

    // Only items that actually write a slot can be forwarded to stage 2
    assign s3_pc    = match_in.pc;
    assign s3_valid = is_hit || do_insert;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            for (int i = 0; i < `PROF_ENTRIES; i++) begin
                entry_count[i] <= '0;
            end
            last_slot   <= '0;
            last_insert <= 1'b0;
        end else begin
            if (is_hit) begin
                if (saturated) begin
                    // Age the whole table, invalid slots stay at zero
                    for (int i = 0; i < `PROF_ENTRIES; i++) begin
                        if (entry_valid[i]) begin
                            entry_count[i] <= entry_count[i] >> 1;
                        end
                    end
                    entry_count[target] <= (entry_count[target] >> 1) + `COUNT_W'(1);
                end else begin
                    entry_count[target] <= entry_count[target] + `COUNT_W'(1);
                end
            end
            if (do_insert) begin
                entry_valid[victim] <= 1'b1;
                entry_count[victim] <= `COUNT_W'(1);
            end
            if (s3_valid) begin
                last_slot <= write_slot;
            end
            last_insert <= do_insert;
        end
    end

    // Branch address storage
    always_ff @(posedge clk) begin
        if (do_insert) begin
            entry_addr[victim] <= match_in.pc;
        end
    end

    always_comb begin
        for (int i = 0; i < `PROF_ENTRIES; i++) begin
            table_state[i].branch_addr = entry_addr[i];
            table_state[i].entry_valid = entry_valid[i];
            table_state[i].taken_count = entry_count[i];
        end
    end

    // Zero latency readout
    assign rd_entry = table_state[rd_index];

endmodule

`default_nettype wire

/* verilog/profile_match.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rca_profiler_config.svh"

module profile_match (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire rca_profiler_pkg::branch_event_t       event_in,
    input  wire rca_profiler_pkg::profiler_entry_t [`PROF_ENTRIES-1:0] table_state,
    input  wire logic [`XLEN-1:0]                      s3_pc,
    input  wire logic                                  s3_valid,
    output rca_profiler_pkg::match_result_t            match_out
);

    logic [`PROF_ENTRIES-1:0] hit_vec;
    logic [`PROF_IDX_W-1:0]   hit_idx;
    logic                     same_pc;

    // Fully associative lookup, at most one entry can match
    always_comb begin
        hit_vec = '0;
        hit_idx = '0;
        for (int i = 0; i < `PROF_ENTRIES; i++) begin
            hit_vec[i] = table_state[i].entry_valid &&
                         (table_state[i].branch_addr == event_in.pc);
            // One-hot to binary by OR of the matching index
            if (hit_vec[i]) begin
                hit_idx = hit_idx | `PROF_IDX_W'(i);
            end
        end
    end

    // Stage 3 writes this PC now, so the table view above is one cycle behind
    assign same_pc = s3_valid && (s3_pc == event_in.pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_out <= '0;
        end else begin
            match_out.valid        <= event_in.valid;
            match_out.pc           <= event_in.pc;
            match_out.sbb          <= event_in.sbb;
            match_out.hit          <= |hit_vec;
            match_out.hit_idx      <= hit_idx;
            match_out.same_as_prev <= same_pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/branch_event_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rca_profiler_config.svh"

module branch_event_filter (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    branch_issue,
    input  wire logic                    branch_taken,
    input  wire logic                    profiler_lock,
    input  wire logic [`XLEN-1:0]        branch_pc,
    input  wire logic [`OFFSET_W-1:0]    branch_offset,
    output rca_profiler_pkg::branch_event_t event_out
);

    logic sbb;
    logic accept;

    // Negative but no further back than the short limit
    assign sbb = branch_offset[`OFFSET_W-1] &&
                 ($signed(branch_offset) >= $signed(`SBB_MAX_OFFSET));

    // Only taken branches are profiled, and nothing while software holds the lock
    assign accept = branch_issue && branch_taken && !profiler_lock;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            event_out <= '0;
        end else begin
            event_out.valid <= accept;
            event_out.pc    <= branch_pc;
            event_out.sbb   <= sbb;
        end
    end

endmodule

`default_nettype wire

/* verilog/rca_profiler_pkg.sv */
`default_nettype none

`include "rca_profiler_config.svh"

package rca_profiler_pkg;

    // Stage 1 result, one per sampled branch
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic              sbb;
    } branch_event_t;

    // Stage 2 result carried into the table update
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic                   sbb;
        logic                   hit;
        logic [`PROF_IDX_W-1:0] hit_idx;
        // PC equals the item written by stage 3 in the same cycle
        logic                   same_as_prev;
    } match_result_t;

    // One profile table slot
    typedef struct packed {
        logic [`XLEN-1:0]    branch_addr;
        logic                entry_valid;
        logic [`COUNT_W-1:0] taken_count;
    } profiler_entry_t;

endpackage

`default_nettype wire

/* verilog/rca_profiler_config.svh */
`ifndef RCA_PROFILER_CONFIG_SVH
`define RCA_PROFILER_CONFIG_SVH

// Width of a branch PC
`define XLEN 32

// Profile table geometry
`define PROF_ENTRIES 8
`define PROF_IDX_W 3

// Taken counter width, all ones means saturated
`define COUNT_W 4

// Signed branch offset as reported by the branch unit
`define OFFSET_W 21

// Most negative offset in bytes that still counts as a short backward branch
`define SBB_MAX_OFFSET (-256)

`endif
